/* vlog.f */
+incdir+include
design/rvfi_pkg.sv
design/rvfi_trace_fsm.sv
design/rvfi_order_counter.sv
design/rvfi_issue_latch.sv
design/rvfi_sb_mem.sv
design/rvfi_pack.sv
design/rvfi_tracer.sv
tests/rvfi_tracer_props.sv
tests/rvfi_tracer_tb.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module rvfi_tracer_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vrvfi_tracer_tb)"; echo "$$out"; \
	echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tests/rvfi_tracer_tb.sv */
// ------------------------------
// Each table row runs six cycles of setup, fetch, decode, LSU, commit and tail
// Inputs change on the falling edge and the record is sampled 5 ns later
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "rvfi_params.svh"

module rvfi_tracer_tb;

  localparam int NUM_TESTS = 8;
  localparam int TIMEOUT   = NUM_TESTS * 6 + 200;

  localparam logic [1:0] SC_NORMAL = 2'd0;
  localparam logic [1:0] SC_OFF    = 2'd1;  // Tracing disabled for the row
  localparam logic [1:0] SC_FLUSH  = 2'd2;  // Flush just before the fetch
  localparam logic [1:0] SC_CLEAR  = 2'd3;

  typedef struct {
    string               name;
    logic [1:0]          scen;
    rvfi_pkg::insn_t     word;
    logic                comp;
    rvfi_pkg::lsu_fu_e   fu;
    rvfi_pkg::xlen_t     addr;
    rvfi_pkg::be_t       be;
    rvfi_pkg::xlen_t     wdata;
    rvfi_pkg::trans_id_t tid;
    logic                ex;
    rvfi_pkg::cause_t    cause;
    rvfi_pkg::priv_lvl_e priv;
    logic                dbg;
    logic                exp_valid;
    logic                exp_trap;
  } row_t;

  logic                    clk;
  logic                    rst;
  logic                    clear;
  logic                    trace_en;
  logic                    flush;
  logic                    fetch_valid;
  rvfi_pkg::insn_t         instr;
  logic                    is_comp;
  logic                    issue_ack;
  rvfi_pkg::trans_id_t     issue_ptr;
  logic                    dec_valid;
  logic                    dec_ack;
  logic                    flush_unissued;
  rvfi_pkg::xlen_t         rs1_fwd;
  rvfi_pkg::xlen_t         rs2_fwd;
  rvfi_pkg::lsu_ctrl_t     lsu_ctrl;
  rvfi_pkg::commit_probe_t commit;
  rvfi_pkg::rvfi_instr_t   rvfi;

  row_t                tbl [NUM_TESTS];
  rvfi_pkg::sb_entry_t model [`RVFI_NR_SB_ENTRIES];  // Expected side memory
  logic                lat_valid;                    // Expected issue latch
  rvfi_pkg::insn_t     lat_word;
  rvfi_pkg::order_t    exp_order;
  integer              seed;
  string               cur_test;
  int                  errors;
  int                  passed;
  int                  cycles;

  rvfi_tracer dut0 (
    .clk_i               (clk),
    .rst_i               (rst),
    .clear_i             (clear),
    .trace_en_i          (trace_en),
    .flush_i             (flush),
    .fetch_entry_valid_i (fetch_valid),
    .instruction_i       (instr),
    .is_compressed_i     (is_comp),
    .issue_ack_i         (issue_ack),
    .issue_pointer_i     (issue_ptr),
    .decoded_valid_i     (dec_valid),
    .decoded_ack_i       (dec_ack),
    .flush_unissued_i    (flush_unissued),
    .rs1_fwd_i           (rs1_fwd),
    .rs2_fwd_i           (rs2_fwd),
    .lsu_ctrl_i          (lsu_ctrl),
    .commit_i            (commit),
    .rvfi_o              (rvfi)
  );

  bind rvfi_tracer rvfi_tracer_props u_props (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .clear_i     (clear_i),
    .trace_en_i  (trace_en_i),
    .report_en_i (report_en),
    .rvfi_i      (rvfi_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic compare_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
    end
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  // Column order is name, scenario, word, compressed, fu, addr, be, wdata, tid,
  // exception, cause, priv, debug, expected valid and expected trap
  task automatic load_table();
    tbl[0] = '{"alu_add", SC_NORMAL, 32'h00b50533, 1'b0, rvfi_pkg::NONE, 32'h0, 4'h0,
               32'h0, 3'd0, 1'b0, 32'd0, rvfi_pkg::M, 1'b0, 1'b1, 1'b0};
    tbl[1] = '{"load_c", SC_NORMAL, 32'hbeef4188, 1'b1, rvfi_pkg::LOAD, 32'h80000010, 4'hf,
               32'h0, 3'd1, 1'b0, 32'd0, rvfi_pkg::S, 1'b0, 1'b1, 1'b0};
    tbl[2] = '{"store_sh", SC_NORMAL, 32'h00b51023, 1'b0, rvfi_pkg::STORE, 32'h80000022,
               4'hc, 32'h12345678, 3'd2, 1'b0, 32'd0, rvfi_pkg::U, 1'b0, 1'b1, 1'b0};
    tbl[3] = '{"ecall_m", SC_NORMAL, 32'h00000073, 1'b0, rvfi_pkg::NONE, 32'h0, 4'h0,
               32'h0, 3'd3, 1'b1, 32'd11, rvfi_pkg::M, 1'b0, 1'b1, 1'b1};
    tbl[4] = '{"illegal", SC_NORMAL, 32'hffffffff, 1'b0, rvfi_pkg::NONE, 32'h0, 4'h0,
               32'h0, 3'd4, 1'b1, 32'd2, rvfi_pkg::M, 1'b0, 1'b0, 1'b1};
    // An ecall here would raise both flags if reporting leaked through
    tbl[5] = '{"trace_off", SC_OFF, 32'h00000073, 1'b0, rvfi_pkg::NONE, 32'h0, 4'h0,
               32'h0, 3'd5, 1'b1, 32'd8, rvfi_pkg::U, 1'b0, 1'b0, 1'b0};
    // Reuses trans id 1, so the load entry must come back unchanged
    tbl[6] = '{"flush_skip", SC_FLUSH, 32'h40b50533, 1'b0, rvfi_pkg::NONE, 32'h0, 4'h0,
               32'h0, 3'd1, 1'b0, 32'd0, rvfi_pkg::M, 1'b0, 1'b1, 1'b0};
    tbl[7] = '{"clear_dbg", SC_CLEAR, 32'h00a12023, 1'b0, rvfi_pkg::STORE, 32'h80000100,
               4'hf, 32'hcafef00d, 3'd6, 1'b0, 32'd0, rvfi_pkg::M, 1'b1, 1'b1, 1'b0};
  endtask

  // ------------------------------
  // One row through the pipeline
  // ------------------------------
  task automatic run_row(input int idx, input row_t r);
    rvfi_pkg::xlen_t pc;
    rvfi_pkg::xlen_t rd_data;
    rvfi_pkg::xlen_t result;
    logic [31:0]     regs;
    logic [1:0]      exp_mode;
    int              errs_before;

    cur_test    = r.name;
    errs_before = errors;

    @(negedge clk);  // Setup
    commit   = '0;
    lsu_ctrl = '0;
    trace_en = (r.scen != SC_OFF);
    flush    = (r.scen == SC_FLUSH);
    clear    = (r.scen == SC_CLEAR);
    if (r.scen == SC_CLEAR) begin
      for (int i = 0; i < `RVFI_NR_SB_ENTRIES; i++) begin
        model[i] = '0;
      end
      lat_word  = '0;
      exp_order = '0;
    end

    @(negedge clk);  // Fetch
    flush       = 1'b0;
    clear       = 1'b0;
    fetch_valid = 1'b1;
    instr       = r.word;
    is_comp     = r.comp;
    // Capture is live only in RUN so OFF and FLUSH rows miss the word
    if (r.scen == SC_NORMAL || r.scen == SC_CLEAR) begin
      lat_valid = 1'b1;
      lat_word  = r.comp ? {16'h0, r.word[15:0]} : r.word;
    end

    @(negedge clk);  // Issue and decode acknowledge
    fetch_valid = 1'b0;
    issue_ack   = 1'b1;
    dec_valid   = 1'b1;
    dec_ack     = 1'b1;
    issue_ptr   = r.tid;
    rs1_fwd     = $random(seed);
    rs2_fwd     = $random(seed);
    if (lat_valid) begin
      model[r.tid]           = '0;
      model[r.tid].rs1_rdata = rs1_fwd;
      model[r.tid].rs2_rdata = rs2_fwd;
      model[r.tid].instr     = lat_word;
    end
    lat_valid = 1'b0;

    @(negedge clk);  // LSU request
    issue_ack         = 1'b0;
    dec_valid         = 1'b0;
    dec_ack           = 1'b0;
    lsu_ctrl.fu       = r.fu;
    lsu_ctrl.vaddr    = r.addr;
    lsu_ctrl.be       = r.be;
    lsu_ctrl.trans_id = r.tid;
    lsu_ctrl.wdata    = r.wdata;
    if (r.be != '0 && r.fu == rvfi_pkg::LOAD) begin
      model[r.tid].lsu_addr = r.addr;
      model[r.tid].rmask    = r.be;
    end else if (r.be != '0 && r.fu == rvfi_pkg::STORE) begin
      model[r.tid].lsu_addr  = r.addr;
      model[r.tid].wmask     = r.be;
      model[r.tid].lsu_wdata = r.wdata;
    end

    @(negedge clk);  // Commit
    lsu_ctrl              = '0;
    regs                  = $random(seed);
    rd_data               = $random(seed);
    result                = $random(seed);
    pc                    = 32'h80000000 + 32'(idx * 4);
    commit.commit_ack     = 1'b1;
    commit.ex_valid       = r.ex;
    commit.ex_cause       = r.cause;
    commit.rs1            = regs[4:0];
    commit.rs2            = regs[9:5];
    commit.rd             = regs[14:10];
    commit.pc             = pc;
    commit.result         = result;
    commit.wdata          = rd_data;
    commit.priv_lvl       = r.priv;
    commit.debug_mode     = r.dbg;
    commit.commit_pointer = r.tid;
    exp_mode              = r.dbg ? 2'd2 : 2'(r.priv);
    #5;
    compare_value("valid", 32'(r.exp_valid), 32'(rvfi.valid));
    compare_value("trap", 32'(r.exp_trap), 32'(rvfi.trap));
    compare_value("order", exp_order, rvfi.order);
    compare_value("insn", model[r.tid].instr, rvfi.insn);
    compare_value("cause", r.cause, rvfi.cause);
    compare_value("mode", 32'(exp_mode), 32'(rvfi.mode));
    compare_value("ixl", 32'd1, 32'(rvfi.ixl));
    compare_value("rs1_addr", 32'(regs[4:0]), 32'(rvfi.rs1_addr));
    compare_value("rs2_addr", 32'(regs[9:5]), 32'(rvfi.rs2_addr));
    compare_value("rd_addr", 32'(regs[14:10]), 32'(rvfi.rd_addr));
    compare_value("rs1_rdata", model[r.tid].rs1_rdata, rvfi.rs1_rdata);
    compare_value("rs2_rdata", model[r.tid].rs2_rdata, rvfi.rs2_rdata);
    compare_value("rd_wdata", rd_data, rvfi.rd_wdata);
    compare_value("pc_rdata", pc, rvfi.pc_rdata);
    compare_value("mem_addr", model[r.tid].lsu_addr, rvfi.mem_addr);
    compare_value("mem_rmask", 32'(model[r.tid].rmask), 32'(rvfi.mem_rmask));
    compare_value("mem_wmask", 32'(model[r.tid].wmask), 32'(rvfi.mem_wmask));
    compare_value("mem_wdata", model[r.tid].lsu_wdata, rvfi.mem_wdata);
    compare_value("mem_rdata", result, rvfi.mem_rdata);
    if (r.exp_valid) begin
      exp_order = exp_order + 32'd1;
    end

    @(negedge clk);  // Tail
    commit   = '0;
    trace_en = 1'b1;

    if (errors == errs_before) begin
      passed++;
      $display("test %0d %s: ok", idx, r.name);
    end else begin
      $display("test %0d %s: %0d mismatches", idx, r.name, errors - errs_before);
    end
  endtask

  initial begin
    seed           = 32'h9eb2;
    clk            = 1'b0;
    rst            = 1'b1;
    clear          = 1'b0;
    trace_en       = 1'b0;
    flush          = 1'b0;
    fetch_valid    = 1'b0;
    instr          = '0;
    is_comp        = 1'b0;
    issue_ack      = 1'b0;
    issue_ptr      = '0;
    dec_valid      = 1'b0;
    dec_ack        = 1'b0;
    flush_unissued = 1'b0;
    rs1_fwd        = '0;
    rs2_fwd        = '0;
    lsu_ctrl       = '0;
    commit         = '0;
    lat_valid      = 1'b0;
    lat_word       = '0;
    exp_order      = '0;
    errors         = 0;
    passed         = 0;
    cycles         = 0;
    for (int i = 0; i < `RVFI_NR_SB_ENTRIES; i++) begin
      model[i] = '0;
    end
    load_table();

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_row(i, tbl[i]);
    end

    $display("Done: %0d tests, %0d ok, %0d failed, %0d mismatches",
             NUM_TESTS, passed, NUM_TESTS - passed, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/rvfi_tracer_props.sv */
// ------------------------------
// Bound to rvfi_tracer, needs its internal report_en wire
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module rvfi_tracer_props (
  input logic                  clk_i,
  input logic                  rst_i,
  input logic                  clear_i,
  input logic                  trace_en_i,
  input logic                  report_en_i,
  input rvfi_pkg::rvfi_instr_t rvfi_i
);

  // Two cycles of disabled tracing silence the record
  a_off_silent: assert property (@(posedge clk_i) disable iff (rst_i)
    (!trace_en_i && $past(!trace_en_i)) |-> !(rvfi_i.valid || rvfi_i.trap))
    else $error("record reported while tracing was disabled");

  // Order moves only after a valid record or a clear
  a_order_step: assert property (@(posedge clk_i) disable iff (rst_i)
    (rvfi_i.order != $past(rvfi_i.order)) |-> ($past(rvfi_i.valid) || $past(clear_i)))
    else $error("order changed without a preceding valid record");

  a_mask_excl: assert property (@(posedge clk_i) disable iff (rst_i)
    !((rvfi_i.mem_rmask != '0) && (rvfi_i.mem_wmask != '0)))
    else $error("read and write masks both nonzero");

  // ------------------------------
  // Reporting holds while enabled
  // ------------------------------
  a_report_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    ($past(report_en_i) && $past(trace_en_i)) |-> report_en_i)
    else $error("report enable dropped while tracing stayed enabled");

endmodule

`default_nettype wire

/* design/rvfi_tracer.sv */
// ------------------------------
// RVFI tracer top, observes the core only
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module rvfi_tracer (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    clear_i,
  input  logic                    trace_en_i,
  // ID stage probes
  input  logic                    flush_i,
  input  logic                    fetch_entry_valid_i,
  input  rvfi_pkg::insn_t         instruction_i,
  input  logic                    is_compressed_i,
  input  logic                    issue_ack_i,
  // Decode probes
  input  rvfi_pkg::trans_id_t     issue_pointer_i,
  input  logic                    decoded_valid_i,
  input  logic                    decoded_ack_i,
  input  logic                    flush_unissued_i,
  input  rvfi_pkg::xlen_t         rs1_fwd_i,
  input  rvfi_pkg::xlen_t         rs2_fwd_i,
  // LSU and commit probes
  input  rvfi_pkg::lsu_ctrl_t     lsu_ctrl_i,
  input  rvfi_pkg::commit_probe_t commit_i,
  output rvfi_pkg::rvfi_instr_t   rvfi_o
);

  logic                capture_en;
  logic                report_en;
  logic                issue_valid;
  rvfi_pkg::insn_t     issue_instr;
  rvfi_pkg::sb_entry_t sb_entry;
  logic                retire;
  rvfi_pkg::order_t    order;

  rvfi_trace_fsm u_trace_fsm (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .trace_en_i   (trace_en_i),
    .flush_i      (flush_i),
    .capture_en_o (capture_en),
    .report_en_o  (report_en)
  );

  rvfi_issue_latch u_issue_latch (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .clear_i             (clear_i),
    .capture_en_i        (capture_en),
    .fetch_entry_valid_i (fetch_entry_valid_i),
    .instruction_i       (instruction_i),
    .is_compressed_i     (is_compressed_i),
    .issue_ack_i         (issue_ack_i),
    .flush_i             (flush_i),
    .issue_valid_o       (issue_valid),
    .issue_instr_o       (issue_instr)
  );

  rvfi_sb_mem u_sb_mem (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .clear_i          (clear_i),
    .capture_en_i     (capture_en),
    .issue_valid_i    (issue_valid),
    .issue_instr_i    (issue_instr),
    .decoded_valid_i  (decoded_valid_i),
    .decoded_ack_i    (decoded_ack_i),
    .flush_unissued_i (flush_unissued_i),
    .issue_pointer_i  (issue_pointer_i),
    .rs1_fwd_i        (rs1_fwd_i),
    .rs2_fwd_i        (rs2_fwd_i),
    .lsu_ctrl_i       (lsu_ctrl_i),
    .rd_pointer_i     (commit_i.commit_pointer),
    .entry_o          (sb_entry)
  );

  rvfi_pack u_pack (
    .report_en_i (report_en),
    .commit_i    (commit_i),
    .entry_i     (sb_entry),
    .order_i     (order),
    .rvfi_o      (rvfi_o),
    .retire_o    (retire)
  );

  rvfi_order_counter u_order_counter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clear_i  (clear_i),
    .retire_i (retire),
    .order_o  (order)
  );

endmodule

`default_nettype wire

/* design/rvfi_pack.sv */
// ------------------------------
// Builds the retirement record in the commit cycle
// Only ecalls retire as valid when trapping
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module rvfi_pack (
  input  logic                    report_en_i,
  input  rvfi_pkg::commit_probe_t commit_i,
  input  rvfi_pkg::sb_entry_t     entry_i,
  input  rvfi_pkg::order_t        order_i,
  output rvfi_pkg::rvfi_instr_t   rvfi_o,
  output logic                    retire_o
);

  // Environment call causes
  localparam rvfi_pkg::cause_t ENV_CALL_UMODE = 32'd8;
  localparam rvfi_pkg::cause_t ENV_CALL_SMODE = 32'd9;
  localparam rvfi_pkg::cause_t ENV_CALL_MMODE = 32'd11;

  logic exception;
  logic is_ecall;

  assign exception = report_en_i && commit_i.ex_valid;
  assign is_ecall  = (commit_i.ex_cause == ENV_CALL_UMODE) ||
                     (commit_i.ex_cause == ENV_CALL_SMODE) ||
                     (commit_i.ex_cause == ENV_CALL_MMODE);

  always_comb begin
    rvfi_o.valid     = report_en_i && ((commit_i.commit_ack && !commit_i.ex_valid) ||
                                       (commit_i.ex_valid && is_ecall));
    rvfi_o.order     = order_i;
    rvfi_o.insn      = entry_i.instr;
    rvfi_o.trap      = exception;
    rvfi_o.cause     = commit_i.ex_cause;
    rvfi_o.mode      = commit_i.debug_mode ? 2'b10 : commit_i.priv_lvl;
    rvfi_o.ixl       = 2'd1;  // RV32
    rvfi_o.rs1_addr  = commit_i.rs1;
    rvfi_o.rs2_addr  = commit_i.rs2;
    rvfi_o.rd_addr   = commit_i.rd;
    rvfi_o.rs1_rdata = entry_i.rs1_rdata;
    rvfi_o.rs2_rdata = entry_i.rs2_rdata;
    rvfi_o.rd_wdata  = commit_i.wdata;
    rvfi_o.pc_rdata  = commit_i.pc;
    rvfi_o.mem_addr  = entry_i.lsu_addr;
    rvfi_o.mem_rmask = entry_i.rmask;
    rvfi_o.mem_wmask = entry_i.wmask;
    rvfi_o.mem_wdata = entry_i.lsu_wdata;
    rvfi_o.mem_rdata = commit_i.result;  // Committed result stands in for load data
  end

  assign retire_o = rvfi_o.valid;

endmodule

`default_nettype wire

/* design/rvfi_sb_mem.sv */
// ------------------------------
// Side memory indexed by transaction id
// A load and a store for one trans id never come together
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "rvfi_params.svh"

module rvfi_sb_mem (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                clear_i,
  input  logic                capture_en_i,
  input  logic                issue_valid_i,
  input  rvfi_pkg::insn_t     issue_instr_i,
  input  logic                decoded_valid_i,
  input  logic                decoded_ack_i,
  input  logic                flush_unissued_i,
  input  rvfi_pkg::trans_id_t issue_pointer_i,
  input  rvfi_pkg::xlen_t     rs1_fwd_i,
  input  rvfi_pkg::xlen_t     rs2_fwd_i,
  input  rvfi_pkg::lsu_ctrl_t lsu_ctrl_i,
  input  rvfi_pkg::trans_id_t rd_pointer_i,
  output rvfi_pkg::sb_entry_t entry_o
);

  rvfi_pkg::sb_entry_t [`RVFI_NR_SB_ENTRIES-1:0] mem_q, mem_n;

  rvfi_pkg::be_t lsu_rmask;
  rvfi_pkg::be_t lsu_wmask;
  logic          issue_write;

  // ------------------------------
  // LSU mask split
  // ------------------------------
  assign lsu_rmask = (lsu_ctrl_i.fu == rvfi_pkg::LOAD)  ? lsu_ctrl_i.be : '0;
  assign lsu_wmask = (lsu_ctrl_i.fu == rvfi_pkg::STORE) ? lsu_ctrl_i.be : '0;

  assign issue_write = capture_en_i && issue_valid_i && decoded_valid_i &&
                       decoded_ack_i && !flush_unissued_i;

  // ------------------------------
  // Entry update
  // ------------------------------
  always_comb begin
    mem_n = mem_q;

    // New instruction starts with clean memory info
    if (issue_write) begin
      mem_n[issue_pointer_i] = '{
        rs1_rdata: rs1_fwd_i,
        rs2_rdata: rs2_fwd_i,
        lsu_addr:  '0,
        rmask:     '0,
        wmask:     '0,
        lsu_wdata: '0,
        instr:     issue_instr_i
      };
    end

    // LSU request lands on an already issued entry
    if (lsu_rmask != '0) begin
      mem_n[lsu_ctrl_i.trans_id].lsu_addr = lsu_ctrl_i.vaddr;
      mem_n[lsu_ctrl_i.trans_id].rmask    = lsu_rmask;
    end else if (lsu_wmask != '0) begin
      mem_n[lsu_ctrl_i.trans_id].lsu_addr  = lsu_ctrl_i.vaddr;
      mem_n[lsu_ctrl_i.trans_id].wmask     = lsu_wmask;
      mem_n[lsu_ctrl_i.trans_id].lsu_wdata = lsu_ctrl_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_n;
    end
  end

  assign entry_o = mem_q[rd_pointer_i];  // Read at the commit pointer

endmodule

`default_nettype wire

/* design/rvfi_issue_latch.sv */
// ------------------------------
// Holds the fetched word until the issue stage takes it
// Compressed words are kept zero-extended above bit 15
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module rvfi_issue_latch (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              clear_i,
  input  logic              capture_en_i,
  input  logic              fetch_entry_valid_i,
  input  rvfi_pkg::insn_t   instruction_i,
  input  logic              is_compressed_i,
  input  logic              issue_ack_i,
  input  logic              flush_i,
  output logic              issue_valid_o,
  output rvfi_pkg::insn_t   issue_instr_o
);

  logic            valid_q, valid_n;
  rvfi_pkg::insn_t instr_q, instr_n;

  always_comb begin
    valid_n = valid_q;
    instr_n = instr_q;

    if (issue_ack_i) begin
      valid_n = 1'b0;  // Word handed to issue
    end

    // Refill when empty or when the current word leaves this cycle
    if (capture_en_i && fetch_entry_valid_i && (!valid_q || issue_ack_i)) begin
      valid_n = 1'b1;
      instr_n = is_compressed_i ? {16'b0, instruction_i[15:0]} : instruction_i;
    end

    if (flush_i) begin
      valid_n = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      valid_q <= 1'b0;
      instr_q <= '0;
    end else begin
      valid_q <= valid_n;
      instr_q <= instr_n;
    end
  end

  assign issue_valid_o = valid_q;
  assign issue_instr_o = instr_q;

endmodule

`default_nettype wire

/* design/rvfi_order_counter.sv */
// ------------------------------
// Holds the order of the next retired record
// Wraps silently after 2**32 retirements
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module rvfi_order_counter (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             clear_i,
  input  logic             retire_i,
  output rvfi_pkg::order_t order_o
);

  rvfi_pkg::order_t order_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      order_q <= '0;
    end else if (retire_i) begin
      order_q <= order_q + 1'b1;  // Advance after each valid record
    end
  end

  assign order_o = order_q;

endmodule

`default_nettype wire

/* design/rvfi_trace_fsm.sv */
// ------------------------------
// Capture is off until trace_en_i is seen high
// One cycle of capture is dropped after each flush
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

module rvfi_trace_fsm (
  input  logic clk_i,
  input  logic rst_i,
  input  logic trace_en_i,
  input  logic flush_i,
  output logic capture_en_o,
  output logic report_en_o
);

  rvfi_pkg::trace_state_e state_q, state_n;

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb begin
    state_n = state_q;
    case (state_q)
      rvfi_pkg::OFF: begin
        if (trace_en_i) begin
          state_n = rvfi_pkg::RUN;
        end
      end
      rvfi_pkg::RUN: begin
        if (flush_i) begin
          state_n = rvfi_pkg::FLUSH;
        end
      end
      rvfi_pkg::FLUSH: state_n = rvfi_pkg::RUN;  // Single blind cycle
      default:         state_n = rvfi_pkg::OFF;
    endcase

    // Disable wins from any state
    if (!trace_en_i) begin
      state_n = rvfi_pkg::OFF;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= rvfi_pkg::OFF;
    end else begin
      state_q <= state_n;
    end
  end

  assign capture_en_o = (state_q == rvfi_pkg::RUN);
  assign report_en_o  = (state_q != rvfi_pkg::OFF);  // In-flight work still retires in FLUSH

endmodule

`default_nettype wire

/* design/rvfi_pkg.sv */
// ------------------------------
// Types shared by the RVFI tracer blocks
// Single commit port, virtual addresses only
// ------------------------------

`default_nettype none

`include "rvfi_params.svh"

package rvfi_pkg;

  // ------------------------------
  // Plain vectors
  // ------------------------------
  typedef logic [`RVFI_XLEN-1:0]          xlen_t;
  typedef logic [`RVFI_TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [`RVFI_XLEN/8-1:0]        be_t;       // One bit per byte lane
  typedef logic [31:0]                    insn_t;
  typedef logic [4:0]                     reg_addr_t;
  typedef logic [31:0]                    order_t;
  typedef logic [31:0]                    cause_t;

  // ------------------------------
  // Enums
  // ------------------------------
  typedef enum logic [1:0] {U = 2'd0, S = 2'd1, M = 2'd3} priv_lvl_e;
  typedef enum logic [1:0] {NONE, LOAD, STORE} lsu_fu_e;
  typedef enum logic [1:0] {OFF, RUN, FLUSH} trace_state_e;

  // ------------------------------
  // Probe and record bundles
  // ------------------------------
  typedef struct packed {
    lsu_fu_e   fu;
    xlen_t     vaddr;
    be_t       be;
    trans_id_t trans_id;
    xlen_t     wdata;       // Store data, ignored for loads
  } lsu_ctrl_t;

  typedef struct packed {
    logic      commit_ack;
    logic      ex_valid;
    cause_t    ex_cause;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     pc;
    xlen_t     result;
    xlen_t     wdata;       // Value written to rd
    priv_lvl_e priv_lvl;
    logic      debug_mode;
    trans_id_t commit_pointer;
  } commit_probe_t;

  typedef struct packed {
    logic       valid;
    order_t     order;
    insn_t      insn;
    logic       trap;
    cause_t     cause;
    logic [1:0] mode;
    logic [1:0] ixl;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    reg_addr_t  rd_addr;
    xlen_t      rs1_rdata;
    xlen_t      rs2_rdata;
    xlen_t      rd_wdata;
    xlen_t      pc_rdata;
    xlen_t      mem_addr;
    be_t        mem_rmask;
    be_t        mem_wmask;
    xlen_t      mem_wdata;
    xlen_t      mem_rdata;
  } rvfi_instr_t;

  // Per-instruction data kept between issue and commit
  typedef struct packed {
    xlen_t rs1_rdata;
    xlen_t rs2_rdata;
    xlen_t lsu_addr;
    be_t   rmask;
    be_t   wmask;
    xlen_t lsu_wdata;
    insn_t instr;
  } sb_entry_t;

endpackage

`default_nettype wire

/* include/rvfi_params.svh */
// ------------------------------
// Widths of the RVFI tracer, XLEN is fixed at 32
// Side memory depth must equal 2**RVFI_TRANS_ID_BITS
// ------------------------------

`ifndef RVFI_PARAMS_SVH
`define RVFI_PARAMS_SVH

// ------------------------------
// Data path
// ------------------------------
`define RVFI_XLEN 32            // Integer register width

// ------------------------------
// Scoreboard tracking
// ------------------------------
`define RVFI_NR_SB_ENTRIES 8    // In-flight instructions tracked
`define RVFI_TRANS_ID_BITS 3    // Index into the side memory

`endif
